// File: run_sim.sh
#!/bin/sh
# build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_fetch -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_fetch +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
exit 0

// File: src/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*; #(
    parameter int BHT_ENTRIES = 16
) (
    input  logic   clk_i,
    input  logic   rstn_i,
    input  addr_t  pc_fetch_i,
    input  logic   upd_valid_i,
    input  logic   upd_taken_i,
    input  addr_t  upd_pc_i,
    input  addr_t  upd_target_i,
    output bpred_t pred_o
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);
    localparam int TAG_W = 62 - IDX_W;

    logic                 valid_q  [BHT_ENTRIES];
    logic [TAG_W-1:0]     tag_q    [BHT_ENTRIES];
    logic [1:0]           ctr_q    [BHT_ENTRIES];
    addr_t                target_q [BHT_ENTRIES];

    logic [IDX_W-1:0]     rd_idx;
    logic [TAG_W-1:0]     rd_tag;
    logic [IDX_W-1:0]     wr_idx;
    logic [TAG_W-1:0]     wr_tag;
    logic                 upd_hit;

    // index from the bits just above the instruction offset
    assign rd_idx = pc_fetch_i[IDX_W+1:2];
    assign rd_tag = pc_fetch_i[63:IDX_W+2];
    assign wr_idx = upd_pc_i[IDX_W+1:2];
    assign wr_tag = upd_pc_i[63:IDX_W+2];

    assign upd_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    // predict taken on a weakly or strongly taken hit
    assign pred_o.taken  = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag) && ctr_q[rd_idx][1];
    assign pred_o.target = target_q[rd_idx];

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_valid_i && upd_taken_i && !upd_hit) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            if (upd_hit) begin
                // saturating 2-bit counter
                if (upd_taken_i && ctr_q[wr_idx] != 2'd3) begin
                    ctr_q[wr_idx] <= ctr_q[wr_idx] + 2'd1;
                end else if (!upd_taken_i && ctr_q[wr_idx] != 2'd0) begin
                    ctr_q[wr_idx] <= ctr_q[wr_idx] - 2'd1;
                end
                target_q[wr_idx] <= upd_target_i;
            end else if (upd_taken_i) begin
                // allocate as weakly taken
                tag_q[wr_idx]    <= wr_tag;
                ctr_q[wr_idx]    <= 2'd2;
                target_q[wr_idx] <= upd_target_i;
            end
        end
    end

endmodule

// File: src/fetch_apb_port.sv
`timescale 1ns/1ps

module fetch_apb_port import fetch_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    fetch_if.consumer pop_if,
    output addr_t     paddr_o,
    output logic      psel_o,
    output logic      penable_o,
    input  inst_t     prdata_i,
    input  logic      pready_i,
    input  logic      pslverr_i,
    output logic      inst_valid_o,
    input  logic      inst_ready_i,
    output addr_t     inst_pc_o,
    output inst_t     inst_o,
    output logic      inst_ex_valid_o,
    output ex_cause_e inst_ex_cause_o,
    output bpred_t    inst_pred_o
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        PRESENT
    } state_e;

    state_e    state_q;
    logic      discard_q;
    addr_t     pc_q;
    bpred_t    bpred_q;
    inst_t     inst_q;
    logic      ex_valid_q;
    ex_cause_e ex_cause_q;

    // one entry at a time, never taken while a redirect is flushing
    assign pop_if.ready = (state_q == IDLE) && !pop_if.flush;

    assign paddr_o   = pc_q;
    assign psel_o    = (state_q == SETUP) || (state_q == ACCESS);
    assign penable_o = state_q == ACCESS;

    assign inst_valid_o    = state_q == PRESENT;
    assign inst_pc_o       = pc_q;
    assign inst_o          = inst_q;
    assign inst_ex_valid_o = ex_valid_q;
    assign inst_ex_cause_o = ex_cause_q;
    assign inst_pred_o     = bpred_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= IDLE;
            discard_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (pop_if.valid && pop_if.ready) begin
                        state_q <= pop_if.entry.ex_valid ? PRESENT : SETUP;
                    end
                end
                SETUP: begin
                    state_q <= ACCESS;
                    if (pop_if.flush) begin
                        discard_q <= 1'b1;
                    end
                end
                ACCESS: begin
                    if (pready_i) begin
                        // a flushed read still finishes on the bus
                        state_q   <= (discard_q || pop_if.flush) ? IDLE : PRESENT;
                        discard_q <= 1'b0;
                    end else if (pop_if.flush) begin
                        discard_q <= 1'b1;
                    end
                end
                PRESENT: begin
                    if (inst_ready_i || pop_if.flush) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && pop_if.valid && pop_if.ready) begin
            pc_q       <= pop_if.entry.pc;
            bpred_q    <= pop_if.entry.bpred;
            inst_q     <= '0;
            ex_valid_q <= pop_if.entry.ex_valid;
            ex_cause_q <= pop_if.entry.ex_cause;
        end else if (state_q == ACCESS && pready_i) begin
            inst_q <= prdata_i;
            if (pslverr_i) begin
                ex_valid_q <= 1'b1;
                ex_cause_q <= INSTR_ACCESS_FAULT;
            end
        end
    end

endmodule

// File: src/fetch_if.sv
`timescale 1ns/1ps

interface fetch_if import fetch_pkg::*; ();

    logic         valid;
    logic         ready;
    fetch_entry_t entry;
    // one-cycle redirect pulse travelling with the entries
    logic         flush;

    modport producer (
        output valid,
        output entry,
        output flush,
        input  ready
    );

    modport consumer (
        input  valid,
        input  entry,
        input  flush,
        output ready
    );

endinterface

// File: src/fetch_pkg.sv
package fetch_pkg;

    // virtual PC and instruction word
    typedef logic [63:0] addr_t;
    typedef logic [31:0] inst_t;

    // fetch exception causes, encoded as in the privileged spec
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1
    } ex_cause_e;

    // prediction attached to one fetched PC
    typedef struct packed {
        logic  taken;
        addr_t target;
    } bpred_t;

    // one entry of the fetch queue
    typedef struct packed {
        addr_t     pc;
        bpred_t    bpred;
        logic      ex_valid;
        ex_cause_e ex_cause;
    } fetch_entry_t;

    // fetch addresses at or above this point have no backing memory
    localparam addr_t PHYS_MEM_LIMIT = 64'h0000_0001_0000_0000;

    // sequential fetch step, one 32-bit instruction
    localparam addr_t PC_STEP = 64'd4;

endpackage

// File: src/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    fetch_if.consumer push_if,
    fetch_if.producer pop_if
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_entry_t     mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_do;
    logic             pop_do;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign push_if.ready = count_q != CNT_W'(QUEUE_DEPTH);
    assign pop_if.valid  = count_q != '0;
    // head entry straight out of the buffer
    assign pop_if.entry  = mem_q[rd_ptr_q];
    assign pop_if.flush  = push_if.flush;

    assign push_do = push_if.valid && push_if.ready && !push_if.flush;
    assign pop_do  = pop_if.valid && pop_if.ready;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (push_if.flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_do) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_do) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push_do && !pop_do) begin
                count_q <= count_q + 1'b1;
            end else if (pop_do && !push_do) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_do) begin
            mem_q[wr_ptr_q] <= push_if.entry;
        end
    end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int BHT_ENTRIES = 16
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  addr_t     reset_addr_i,
    input  logic      redirect_valid_i,
    input  addr_t     redirect_pc_i,
    input  logic      upd_valid_i,
    input  logic      upd_taken_i,
    input  addr_t     upd_pc_i,
    input  addr_t     upd_target_i,
    output addr_t     paddr_o,
    output logic      psel_o,
    output logic      penable_o,
    input  inst_t     prdata_i,
    input  logic      pready_i,
    input  logic      pslverr_i,
    output logic      inst_valid_o,
    input  logic      inst_ready_i,
    output addr_t     inst_pc_o,
    output inst_t     inst_o,
    output logic      inst_ex_valid_o,
    output ex_cause_e inst_ex_cause_o,
    output logic      inst_pred_taken_o,
    output addr_t     inst_pred_target_o
);

    bpred_t inst_pred;

    fetch_if push_if ();
    fetch_if pop_if ();

    pc_gen #(
        .BHT_ENTRIES(BHT_ENTRIES)
    ) i_pc_gen (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .reset_addr_i    (reset_addr_i),
        .redirect_valid_i(redirect_valid_i),
        .redirect_pc_i   (redirect_pc_i),
        .upd_valid_i     (upd_valid_i),
        .upd_taken_i     (upd_taken_i),
        .upd_pc_i        (upd_pc_i),
        .upd_target_i    (upd_target_i),
        .push_if         (push_if)
    );

    fetch_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_fetch_queue (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .push_if(push_if),
        .pop_if (pop_if)
    );

    fetch_apb_port i_fetch_apb_port (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .pop_if         (pop_if),
        .paddr_o        (paddr_o),
        .psel_o         (psel_o),
        .penable_o      (penable_o),
        .prdata_i       (prdata_i),
        .pready_i       (pready_i),
        .pslverr_i      (pslverr_i),
        .inst_valid_o   (inst_valid_o),
        .inst_ready_i   (inst_ready_i),
        .inst_pc_o      (inst_pc_o),
        .inst_o         (inst_o),
        .inst_ex_valid_o(inst_ex_valid_o),
        .inst_ex_cause_o(inst_ex_cause_o),
        .inst_pred_o    (inst_pred)
    );

    // prediction leaves the core as two plain signals
    assign inst_pred_taken_o  = inst_pred.taken;
    assign inst_pred_target_o = inst_pred.target;

endmodule

// File: src/pc_gen.sv
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; #(
    parameter int BHT_ENTRIES = 16
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  addr_t     reset_addr_i,
    input  logic      redirect_valid_i,
    input  addr_t     redirect_pc_i,
    input  logic      upd_valid_i,
    input  logic      upd_taken_i,
    input  addr_t     upd_pc_i,
    input  addr_t     upd_target_i,
    fetch_if.producer push_if
);

    addr_t  pc_q;
    logic   halted_q;
    logic   stall_q;
    bpred_t bpred_q;
    bpred_t pred_lookup;
    bpred_t bpred_cur;
    logic   misaligned;
    logic   access_fault;
    logic   ex_valid;
    logic   push_done;

    branch_predictor #(
        .BHT_ENTRIES(BHT_ENTRIES)
    ) i_bpred (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .pc_fetch_i  (pc_q),
        .upd_valid_i (upd_valid_i),
        .upd_taken_i (upd_taken_i),
        .upd_pc_i    (upd_pc_i),
        .upd_target_i(upd_target_i),
        .pred_o      (pred_lookup)
    );

    // keep the first prediction while the push waits, training may change the table
    assign bpred_cur = stall_q ? bpred_q : pred_lookup;

    assign misaligned   = |pc_q[1:0];
    assign access_fault = pc_q >= PHYS_MEM_LIMIT;
    assign ex_valid     = misaligned || access_fault;

    assign push_if.valid          = !halted_q;
    assign push_if.flush          = redirect_valid_i;
    assign push_if.entry.pc       = pc_q;
    assign push_if.entry.bpred    = ex_valid ? '0 : bpred_cur;
    assign push_if.entry.ex_valid = ex_valid;
    assign push_if.entry.ex_cause = misaligned ? INSTR_ADDR_MISALIGNED : INSTR_ACCESS_FAULT;

    assign push_done = push_if.valid && push_if.ready;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q     <= reset_addr_i;
            halted_q <= 1'b0;
            stall_q  <= 1'b0;
        end else if (redirect_valid_i) begin
            pc_q     <= redirect_pc_i;
            halted_q <= 1'b0;
            stall_q  <= 1'b0;
        end else if (push_done) begin
            pc_q     <= bpred_cur.taken ? bpred_cur.target : pc_q + PC_STEP;
            // a faulting entry ends the stream until the back end redirects
            halted_q <= ex_valid;
            stall_q  <= 1'b0;
        end else if (push_if.valid) begin
            stall_q  <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_q) begin
            bpred_q <= pred_lookup;
        end
    end

endmodule

// File: tb.f
src/fetch_pkg.sv
src/fetch_if.sv
src/branch_predictor.sv
src/pc_gen.sv
src/fetch_queue.sv
src/fetch_apb_port.sv
src/fetch_top.sv
tb/fetch_props.sv
tb/tb_fetch.sv

// File: tb/fetch_props.sv
`timescale 1ns/1ps

module fetch_props import fetch_pkg::*; (
    input logic  clk_i,
    input logic  rstn_i,
    input logic  psel_o,
    input logic  penable_o,
    input addr_t paddr_o,
    input logic  pready_i,
    input logic  inst_valid_o,
    input logic  inst_ready_i,
    input addr_t inst_pc_o,
    input inst_t inst_o,
    input logic  inst_ex_valid_o
);

    int unsigned fail_count = 0;

    // setup phase lasts exactly one cycle
    a_setup_to_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
        psel_o && !penable_o |=> psel_o && penable_o)
        else begin
            $error("APB setup cycle not followed by an access cycle");
            fail_count++;
        end

    a_paddr_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        psel_o && !(penable_o && pready_i) |=> $stable(paddr_o))
        else begin
            $error("APB address changed during a transfer");
            fail_count++;
        end

    // decode data holds while stalled
    a_inst_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        inst_valid_o && !inst_ready_i |=> inst_valid_o && $stable(inst_pc_o)
            && $stable(inst_o) && $stable(inst_ex_valid_o))
        else begin
            $error("decode output changed under back-pressure");
            fail_count++;
        end

endmodule

bind fetch_apb_port fetch_props i_props (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .psel_o         (psel_o),
    .penable_o      (penable_o),
    .paddr_o        (paddr_o),
    .pready_i       (pready_i),
    .inst_valid_o   (inst_valid_o),
    .inst_ready_i   (inst_ready_i),
    .inst_pc_o      (inst_pc_o),
    .inst_o         (inst_o),
    .inst_ex_valid_o(inst_ex_valid_o)
);

// File: tb/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

    localparam logic [31:0] SEED          = 32'hc8e38af2;
    localparam addr_t       RESET_ADDR    = 64'h0000_0000_8000_0000;
    localparam addr_t       ERR_ADDR      = 64'h0000_0000_8000_2010;
    localparam addr_t       BR_PC         = 64'h0000_0000_8000_0100;
    localparam addr_t       BR_TARGET     = 64'h0000_0000_8000_0400;
    localparam addr_t       MIS_PC        = 64'h0000_0000_8000_0202;
    localparam int          WAIT_LIMIT    = 64;
    localparam int          SILENT_CYCLES = 20;

    logic      clk_i = 1'b0;
    logic      rstn_i;
    addr_t     reset_addr_i;
    logic      redirect_valid_i;
    addr_t     redirect_pc_i;
    logic      upd_valid_i;
    logic      upd_taken_i;
    addr_t     upd_pc_i;
    addr_t     upd_target_i;
    addr_t     paddr_o;
    logic      psel_o;
    logic      penable_o;
    inst_t     prdata_i = '0;
    logic      pready_i = 1'b0;
    logic      pslverr_i = 1'b0;
    logic      inst_valid_o;
    logic      inst_ready_i;
    addr_t     inst_pc_o;
    inst_t     inst_o;
    logic      inst_ex_valid_o;
    ex_cause_e inst_ex_cause_o;
    logic      inst_pred_taken_o;
    addr_t     inst_pred_target_o;

    // memory model state
    logic        in_access = 1'b0;
    int          wait_left = 0;
    logic [31:0] wait_rng = SEED ^ 32'h5a5a_0f0f;
    logic        wait_en = 1'b0;
    addr_t       watch_addr = '1;
    int          watch_count = 0;

    // decode side state
    logic [31:0] ready_rng = SEED;
    logic        bp_en = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          err_mark = 0;

    always #2 clk_i = ~clk_i;

    fetch_top #(
        .QUEUE_DEPTH(4),
        .BHT_ENTRIES(16)
    ) i_dut (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .reset_addr_i      (reset_addr_i),
        .redirect_valid_i  (redirect_valid_i),
        .redirect_pc_i     (redirect_pc_i),
        .upd_valid_i       (upd_valid_i),
        .upd_taken_i       (upd_taken_i),
        .upd_pc_i          (upd_pc_i),
        .upd_target_i      (upd_target_i),
        .paddr_o           (paddr_o),
        .psel_o            (psel_o),
        .penable_o         (penable_o),
        .prdata_i          (prdata_i),
        .pready_i          (pready_i),
        .pslverr_i         (pslverr_i),
        .inst_valid_o      (inst_valid_o),
        .inst_ready_i      (inst_ready_i),
        .inst_pc_o         (inst_pc_o),
        .inst_o            (inst_o),
        .inst_ex_valid_o   (inst_ex_valid_o),
        .inst_ex_cause_o   (inst_ex_cause_o),
        .inst_pred_taken_o (inst_pred_taken_o),
        .inst_pred_target_o(inst_pred_target_o)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory contents, a hash over both address halves
    function automatic inst_t mem_word(input addr_t a);
        logic [31:0] x;
        x = lcg_step(a[31:0] ^ SEED);
        x = lcg_step(x ^ (x >> 13) ^ a[63:32]);
        return x;
    endfunction

    // APB slave with random wait states and one erroring address
    always @(posedge clk_i) begin
        #1;
        if (psel_o && penable_o) begin
            if (!in_access) begin
                in_access = 1'b1;
                wait_rng  = lcg_step(wait_rng);
                wait_left = wait_en ? int'(wait_rng[17:16]) : 0;
            end else if (wait_left > 0) begin
                wait_left = wait_left - 1;
            end
        end else begin
            in_access = 1'b0;
        end
        pready_i  = in_access && (wait_left == 0);
        prdata_i  = in_access ? mem_word(paddr_o) : '0;
        pslverr_i = pready_i && (paddr_o == ERR_ADDR);
    end

    // counts bus reads to one watched address
    always @(posedge clk_i) begin
        #2;
        if (psel_o && paddr_o == watch_addr) begin
            watch_count = watch_count + 1;
        end
    end

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cause(input string name, input ex_cause_e got, input ex_cause_e exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // returns with got set in the cycle whose closing edge takes the instruction
    task automatic wait_handshake(output logic got);
        int cycles;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < WAIT_LIMIT) begin
            @(posedge clk_i);
            #1;
            ready_rng    = lcg_step(ready_rng);
            inst_ready_i = bp_en ? ready_rng[20] : 1'b1;
            #1;
            got    = inst_valid_o && inst_ready_i;
            cycles = cycles + 1;
        end
        if (!got) begin
            $display("timeout: no instruction reached decode within %0d cycles", WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic expect_inst(input addr_t pc, input logic ex, input ex_cause_e cause,
                               input logic taken, input addr_t target);
        logic got;
        wait_handshake(got);
        if (got) begin
            check_addr("inst_pc_o", inst_pc_o, pc);
            check_bit("inst_ex_valid_o", inst_ex_valid_o, ex);
            if (ex) begin
                check_cause("inst_ex_cause_o", inst_ex_cause_o, cause);
            end else begin
                check_inst("inst_o", inst_o, mem_word(pc));
            end
            check_bit("inst_pred_taken_o", inst_pred_taken_o, taken);
            if (taken) begin
                check_addr("inst_pred_target_o", inst_pred_target_o, target);
            end
        end
    endtask

    task automatic expect_run(input addr_t start, input int count);
        addr_t pc;
        pc = start;
        for (int i = 0; i < count; i++) begin
            expect_inst(pc, 1'b0, INSTR_ADDR_MISALIGNED, 1'b0, '0);
            // one 32-bit instruction per step
            pc = pc + 64'd4;
        end
    endtask

    task automatic expect_silence(input int cycles);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_i);
            #1;
            inst_ready_i = 1'b1;
            #1;
            if (inst_valid_o) begin
                seen = 1'b1;
            end
        end
        checks++;
        if (seen) begin
            $display("error: an instruction reached decode after a fault with no redirect");
            errors++;
        end
    endtask

    // the presented instruction is dropped by the flush in this cycle
    task automatic drive_redirect(input addr_t pc);
        @(posedge clk_i);
        #1;
        redirect_valid_i = 1'b1;
        redirect_pc_i    = pc;
        inst_ready_i     = 1'b1;
        @(posedge clk_i);
        #1;
        redirect_valid_i = 1'b0;
        inst_ready_i     = 1'b0;
    endtask

    task automatic train(input addr_t pc, input logic taken, input addr_t target);
        @(posedge clk_i);
        #1;
        upd_valid_i  = 1'b1;
        upd_taken_i  = taken;
        upd_pc_i     = pc;
        upd_target_i = target;
        inst_ready_i = 1'b0;
        @(posedge clk_i);
        #1;
        upd_valid_i = 1'b0;
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d errors", name, errors - err_mark);
        tests++;
        err_mark = errors;
    endtask

    initial begin
        rstn_i           = 1'b0;
        reset_addr_i     = RESET_ADDR;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        upd_valid_i      = 1'b0;
        upd_taken_i      = 1'b0;
        upd_pc_i         = '0;
        upd_target_i     = '0;
        inst_ready_i     = 1'b0;
        repeat (10) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        expect_run(RESET_ADDR, 8);
        finish_test("sequential fetch");

        bp_en   = 1'b1;
        wait_en = 1'b1;
        drive_redirect(64'h0000_0000_8000_0800);
        expect_run(64'h0000_0000_8000_0800, 24);
        bp_en   = 1'b0;
        wait_en = 1'b0;
        finish_test("back-pressure and wait states");

        drive_redirect(64'h0000_0000_8000_1000);
        expect_run(64'h0000_0000_8000_1000, 8);
        finish_test("redirect");

        train(BR_PC, 1'b1, BR_TARGET);
        drive_redirect(BR_PC - 64'd8);
        expect_run(BR_PC - 64'd8, 2);
        expect_inst(BR_PC, 1'b0, INSTR_ADDR_MISALIGNED, 1'b1, BR_TARGET);
        expect_inst(BR_TARGET, 1'b0, INSTR_ADDR_MISALIGNED, 1'b0, '0);
        // two not-taken updates weaken the counter below the taken threshold
        train(BR_PC, 1'b0, BR_TARGET);
        train(BR_PC, 1'b0, BR_TARGET);
        drive_redirect(BR_PC - 64'd8);
        expect_run(BR_PC - 64'd8, 4);
        finish_test("branch prediction");

        watch_addr = MIS_PC;
        drive_redirect(MIS_PC);
        expect_inst(MIS_PC, 1'b1, INSTR_ADDR_MISALIGNED, 1'b0, '0);
        expect_silence(SILENT_CYCLES);
        checks++;
        if (watch_count != 0) begin
            $display("error: an APB read was issued for a misaligned PC");
            errors++;
        end
        drive_redirect(PHYS_MEM_LIMIT);
        expect_inst(PHYS_MEM_LIMIT, 1'b1, INSTR_ACCESS_FAULT, 1'b0, '0);
        expect_silence(SILENT_CYCLES);
        drive_redirect(ERR_ADDR - 64'd4);
        expect_inst(ERR_ADDR - 64'd4, 1'b0, INSTR_ADDR_MISALIGNED, 1'b0, '0);
        expect_inst(ERR_ADDR, 1'b1, INSTR_ACCESS_FAULT, 1'b0, '0);
        finish_test("exceptions");

        // failed bus and handshake assertions count as errors too
        errors = errors + int'(i_dut.i_fetch_apb_port.i_props.fail_count);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
